// ==== src/rtio_pkg.sv ====
package rtio_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int TS_W        = 64;
    localparam int PAYLOAD_W   = 64;
    localparam int WB_DW       = 32;
    localparam int WB_AW       = 8;
    localparam int EDGE_CNT_W  = 32;
    localparam int FIFO_LVL_W  = 8;
    localparam int DDS_AMP_W   = 14;
    localparam int DDS_PHASE_W = 14;
    localparam int DDS_FTW_W   = 32;
    localparam int CNT_CTRL_W  = 4;

    //////////////////////////////
    // Register map, byte offsets
    //////////////////////////////
    localparam logic [WB_AW-1:0] REG_CTRL       = 8'h00;
    localparam logic [WB_AW-1:0] REG_STATUS     = 8'h04;
    localparam logic [WB_AW-1:0] REG_TS_LO      = 8'h10;
    localparam logic [WB_AW-1:0] REG_TS_HI      = 8'h14;
    localparam logic [WB_AW-1:0] REG_PL_LO      = 8'h18;
    localparam logic [WB_AW-1:0] REG_PL_HI      = 8'h1C;
    localparam logic [WB_AW-1:0] REG_PUSH_DDS   = 8'h20;
    localparam logic [WB_AW-1:0] REG_PUSH_CNT   = 8'h24;
    localparam logic [WB_AW-1:0] REG_EDGE_COUNT = 8'h30;

    // Field positions in CTRL and STATUS
    localparam int CTRL_RUN_BIT    = 0;
    localparam int CTRL_TCLR_BIT   = 1;
    localparam int STATUS_FULL_BIT = 0;
    localparam int STATUS_LVL_LSB  = 8;

    // Counter control field bits
    localparam int CNT_ARM_RISE = 0;
    localparam int CNT_ARM_FALL = 1;
    localparam int CNT_CLEAR    = 2;

    typedef enum logic {
        DEST_DDS = 1'b0,
        DEST_CNT = 1'b1
    } rtio_dest_e;

    // Queued command is {dest, timestamp, payload}
    localparam int CMD_W        = TS_W + PAYLOAD_W + 1;
    localparam int CMD_TS_LSB   = PAYLOAD_W;
    localparam int CMD_DEST_BIT = TS_W + PAYLOAD_W;

    // One payload word, two readings chosen by the destination
    typedef union packed {
        struct packed {
            logic [3:0]             rsvd;
            logic [DDS_AMP_W-1:0]   amp;
            logic [DDS_PHASE_W-1:0] phase;
            logic [DDS_FTW_W-1:0]   ftw;
        } dds;
        struct packed {
            logic [PAYLOAD_W-CNT_CTRL_W-1:0] rsvd;
            logic [CNT_CTRL_W-1:0]           ctrl;
        } cnt;
    } rtio_payload_u;

endpackage

// ==== src/rtio_edge_counter.sv ====
`timescale 1ns/1ns

module rtio_edge_counter
    import rtio_pkg::*;
(
    input  logic                  rtio_clk_i,
    input  logic                  rst_n_i,
    input  logic                  edge_sig_i,
    input  logic                  ctrl_load_i,
    input  logic [CNT_CTRL_W-1:0] ctrl_i,
    output logic [EDGE_CNT_W-1:0] count_o
);

    // Two sync flops, then one more for the previous level
    logic sync1_q;
    logic sync2_q;
    logic prev_q;
    logic arm_rise_q;
    logic arm_fall_q;
    logic rise_w;
    logic fall_w;
    logic [EDGE_CNT_W-1:0] count_q;

    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            prev_q  <= 1'b0;
        end else begin
            sync1_q <= edge_sig_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
        end
    end

    assign rise_w = sync2_q & ~prev_q;
    assign fall_w = ~sync2_q & prev_q;

    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arm_rise_q <= 1'b0;
            arm_fall_q <= 1'b0;
            count_q    <= '0;
        end else begin
            if (ctrl_load_i) begin
                arm_rise_q <= ctrl_i[CNT_ARM_RISE];
                arm_fall_q <= ctrl_i[CNT_ARM_FALL];
            end
            // Clear wins over an edge in the same cycle
            if (ctrl_load_i && ctrl_i[CNT_CLEAR]) begin
                count_q <= '0;
            end else if ((rise_w && arm_rise_q) || (fall_w && arm_fall_q)) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    assign count_o = count_q;

endmodule

// ==== src/rtio_wb_slave.sv ====
`timescale 1ns/1ns

module rtio_wb_slave
    import rtio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  rtio_clk_i,
    input  logic                  rst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [WB_AW-1:0]      wb_adr_i,
    input  logic [WB_DW-1:0]      wb_dat_i,
    input  logic                  fifo_full_i,
    input  logic [FIFO_LVL_W-1:0] fifo_level_i,
    input  logic [EDGE_CNT_W-1:0] edge_count_i,
    output logic [WB_DW-1:0]      wb_dat_o,
    output logic                  wb_ack_o,
    output logic                  push_o,
    output logic [CMD_W-1:0]      push_cmd_o,
    output logic                  run_o,
    output logic                  time_clear_o
);

    // Level bits that can be nonzero for this depth
    localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

    logic             access;
    logic             is_push;
    logic             stall;
    logic             start;
    logic             wr_en;
    logic             ack_q;
    logic             run_q;
    logic             tclr_q;
    logic [WB_DW-1:0] ts_lo_q;
    logic [WB_DW-1:0] ts_hi_q;
    logic [WB_DW-1:0] pl_lo_q;
    logic [WB_DW-1:0] pl_hi_q;
    logic [WB_DW-1:0] status_w;
    logic [WB_DW-1:0] rd_mux;
    logic [WB_DW-1:0] dat_q;
    rtio_dest_e       push_dest;

    //////////////////////////////
    // Bus handshake
    //////////////////////////////
    assign access  = wb_cyc_i & wb_stb_i;
    assign is_push = (wb_adr_i == REG_PUSH_DDS) || (wb_adr_i == REG_PUSH_CNT);
    // Push write waits here while the FIFO has no room
    assign stall   = wb_we_i & is_push & fifo_full_i;
    // First cycle of an access that can complete
    assign start   = access & ~ack_q & ~stall;
    assign wr_en   = start & wb_we_i;

    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            // Once given, ack holds until stb drops
            ack_q <= access & (ack_q | ~stall);
        end
    end

    // Gated by stb so ack falls together with it
    assign wb_ack_o = ack_q & access;

    //////////////////////////////
    // Control register
    //////////////////////////////
    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q  <= 1'b0;
            tclr_q <= 1'b0;
        end else begin
            tclr_q <= 1'b0;
            if (wr_en && wb_adr_i == REG_CTRL) begin
                run_q  <= wb_dat_i[CTRL_RUN_BIT];
                tclr_q <= wb_dat_i[CTRL_TCLR_BIT];
            end
        end
    end

    assign run_o        = run_q;
    assign time_clear_o = tclr_q;

    // Staging words for the next command
    always_ff @(posedge rtio_clk_i) begin
        if (wr_en) begin
            case (wb_adr_i)
                REG_TS_LO: ts_lo_q <= wb_dat_i;
                REG_TS_HI: ts_hi_q <= wb_dat_i;
                REG_PL_LO: pl_lo_q <= wb_dat_i;
                REG_PL_HI: pl_hi_q <= wb_dat_i;
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // Command push
    //////////////////////////////
    assign push_dest  = (wb_adr_i == REG_PUSH_CNT) ? DEST_CNT : DEST_DDS;
    assign push_o     = wr_en & is_push;
    assign push_cmd_o = {push_dest, ts_hi_q, ts_lo_q, pl_hi_q, pl_lo_q};

    //////////////////////////////
    // Readback
    //////////////////////////////
    always_comb begin
        status_w = '0;
        status_w[STATUS_FULL_BIT] = fifo_full_i;
        status_w[STATUS_LVL_LSB +: LVL_W] = fifo_level_i[LVL_W-1:0];
    end

    always_comb begin
        rd_mux = '0;
        case (wb_adr_i)
            REG_CTRL:       rd_mux[CTRL_RUN_BIT] = run_q;
            REG_STATUS:     rd_mux = status_w;
            REG_TS_LO:      rd_mux = ts_lo_q;
            REG_TS_HI:      rd_mux = ts_hi_q;
            REG_PL_LO:      rd_mux = pl_lo_q;
            REG_PL_HI:      rd_mux = pl_hi_q;
            REG_EDGE_COUNT: rd_mux = edge_count_i;
            default:        rd_mux = '0;
        endcase
    end

    // Read data sampled with the cycle that raises ack
    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dat_q <= '0;
        end else if (start && !wb_we_i) begin
            dat_q <= rd_mux;
        end
    end

    assign wb_dat_o = dat_q;

endmodule

// ==== src/rtio_event_fifo.sv ====
`timescale 1ns/1ns

module rtio_event_fifo
    import rtio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                  rtio_clk_i,
    input  logic                  rst_n_i,
    input  logic                  push_i,
    input  logic [CMD_W-1:0]      push_cmd_i,
    input  logic                  pop_i,
    output logic [CMD_W-1:0]      head_cmd_o,
    output logic                  empty_o,
    output logic                  full_o,
    output logic [FIFO_LVL_W-1:0] level_o
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [CMD_W-1:0] mem [FIFO_DEPTH];
    // Extra MSB tells a full ring from an empty one
    logic [AW:0]      wr_ptr;
    logic [AW:0]      rd_ptr;
    logic [AW:0]      fill;
    logic             do_push;
    logic             do_pop;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign fill    = wr_ptr - rd_ptr;
    assign level_o = FIFO_LVL_W'(fill);

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Storage
    always_ff @(posedge rtio_clk_i) begin
        if (do_push) begin
            mem[wr_ptr[AW-1:0]] <= push_cmd_i;
        end
    end

    // Pointers
    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Show-ahead, head valid whenever not empty
    assign head_cmd_o = mem[rd_ptr[AW-1:0]];

endmodule

// ==== src/rtio_event_exec.sv ====
`timescale 1ns/1ns

module rtio_event_exec
    import rtio_pkg::*;
(
    input  logic                   rtio_clk_i,
    input  logic                   rst_n_i,
    input  logic                   run_i,
    input  logic                   time_clear_i,
    input  logic [CMD_W-1:0]       head_cmd_i,
    input  logic                   empty_i,
    input  logic                   edge_sig_i,
    output logic                   pop_o,
    output logic [DDS_FTW_W-1:0]   dds_ftw_o,
    output logic [DDS_PHASE_W-1:0] dds_phase_o,
    output logic [DDS_AMP_W-1:0]   dds_amp_o,
    output logic                   dds_update_o,
    output logic [EDGE_CNT_W-1:0]  edge_count_o
);

    logic [TS_W-1:0] time_q;
    logic [TS_W-1:0] head_ts;
    rtio_payload_u   head_pl;
    rtio_dest_e      head_dest;
    logic            pop_w;
    logic            dds_load;
    logic            cnt_load;

    //////////////////////////////
    // Time counter
    //////////////////////////////
    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            time_q <= '0;
        end else if (time_clear_i) begin
            time_q <= '0;
        end else if (run_i) begin
            time_q <= time_q + 1'b1;
        end
    end

    //////////////////////////////
    // Head decode and pop
    //////////////////////////////
    assign head_ts   = head_cmd_i[CMD_TS_LSB +: TS_W];
    assign head_pl   = head_cmd_i[PAYLOAD_W-1:0];
    assign head_dest = rtio_dest_e'(head_cmd_i[CMD_DEST_BIT]);

    // Due once the timestamp has been reached, one per cycle
    assign pop_w = run_i & ~empty_i & (head_ts <= time_q);
    assign pop_o = pop_w;

    assign dds_load = pop_w & (head_dest == DEST_DDS);
    assign cnt_load = pop_w & (head_dest == DEST_CNT);

    //////////////////////////////
    // DDS settings
    //////////////////////////////
    always_ff @(posedge rtio_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dds_ftw_o    <= '0;
            dds_phase_o  <= '0;
            dds_amp_o    <= '0;
            dds_update_o <= 1'b0;
        end else begin
            // Strobe marks the cycle the new settings appear
            dds_update_o <= dds_load;
            if (dds_load) begin
                dds_ftw_o   <= head_pl.dds.ftw;
                dds_phase_o <= head_pl.dds.phase;
                dds_amp_o   <= head_pl.dds.amp;
            end
        end
    end

    // Counter control applied at the edge ending the pop
    rtio_edge_counter u_edge_counter (
        .rtio_clk_i  (rtio_clk_i),
        .rst_n_i     (rst_n_i),
        .edge_sig_i  (edge_sig_i),
        .ctrl_load_i (cnt_load),
        .ctrl_i      (head_pl.cnt.ctrl),
        .count_o     (edge_count_o)
    );

endmodule

// ==== src/rtio_core_top.sv ====
`timescale 1ns/1ns

module rtio_core_top
    import rtio_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   rtio_clk_i,
    input  logic                   rst_n_i,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [WB_AW-1:0]       wb_adr_i,
    input  logic [WB_DW-1:0]       wb_dat_i,
    output logic [WB_DW-1:0]       wb_dat_o,
    output logic                   wb_ack_o,
    input  logic                   edge_sig_i,
    output logic [DDS_FTW_W-1:0]   dds_ftw_o,
    output logic [DDS_PHASE_W-1:0] dds_phase_o,
    output logic [DDS_AMP_W-1:0]   dds_amp_o,
    output logic                   dds_update_o
);

    logic                  push;
    logic [CMD_W-1:0]      push_cmd;
    logic                  fifo_full;
    logic                  fifo_empty;
    logic [FIFO_LVL_W-1:0] fifo_level;
    logic [CMD_W-1:0]      head_cmd;
    logic                  pop;
    logic                  run;
    logic                  time_clear;
    logic [EDGE_CNT_W-1:0] edge_count;

    //////////////////////////////
    // Bus side, command producer
    //////////////////////////////
    rtio_wb_slave #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_wb_slave (
        .rtio_clk_i   (rtio_clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .fifo_full_i  (fifo_full),
        .fifo_level_i (fifo_level),
        .edge_count_i (edge_count),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .push_o       (push),
        .push_cmd_o   (push_cmd),
        .run_o        (run),
        .time_clear_o (time_clear)
    );

    // Command queue
    rtio_event_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_event_fifo (
        .rtio_clk_i (rtio_clk_i),
        .rst_n_i    (rst_n_i),
        .push_i     (push),
        .push_cmd_i (push_cmd),
        .pop_i      (pop),
        .head_cmd_o (head_cmd),
        .empty_o    (fifo_empty),
        .full_o     (fifo_full),
        .level_o    (fifo_level)
    );

    //////////////////////////////
    // Timed executor
    //////////////////////////////
    rtio_event_exec u_event_exec (
        .rtio_clk_i   (rtio_clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run),
        .time_clear_i (time_clear),
        .head_cmd_i   (head_cmd),
        .empty_i      (fifo_empty),
        .edge_sig_i   (edge_sig_i),
        .pop_o        (pop),
        .dds_ftw_o    (dds_ftw_o),
        .dds_phase_o  (dds_phase_o),
        .dds_amp_o    (dds_amp_o),
        .dds_update_o (dds_update_o),
        .edge_count_o (edge_count)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk_o
);

    // Free running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

// ==== test/rtio_core_sva.sv ====
`timescale 1ns/1ns

module rtio_core_sva (
    input logic rtio_clk_i,
    input logic rst_n_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic dds_update_i
);

    //////////////////////////////
    // Wishbone handshake
    //////////////////////////////

    // Ack only inside an active cycle
    ack_needs_cyc_stb: assert property (@(posedge rtio_clk_i) disable iff (!rst_n_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else $error("ack seen without cyc and stb");

    // Slave lets go of ack as soon as stb drops
    ack_drops_with_stb: assert property (@(posedge rtio_clk_i) disable iff (!rst_n_i)
        $fell(wb_stb_i) |-> !wb_ack_i)
        else $error("ack still high after stb dropped");

    // Outputs quiet while reset is held
    quiet_in_reset: assert property (@(posedge rtio_clk_i)
        !rst_n_i |-> (!wb_ack_i && !dds_update_i))
        else $error("ack or dds update during reset");

endmodule

bind rtio_core_top rtio_core_sva sva0 (
    .rtio_clk_i   (rtio_clk_i),
    .rst_n_i      (rst_n_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_ack_i     (wb_ack_o),
    .dds_update_i (dds_update_o)
);

// ==== test/rtio_core_tb.sv ====
`timescale 1ns/1ns

module rtio_core_tb
    import rtio_pkg::*;
();

    localparam int FIFO_DEPTH      = 8;
    localparam int NUM_DDS         = 40;
    localparam int NUM_GATE        = 6;
    localparam int NUM_CNT         = 3;
    localparam int TOTAL_CMDS      = NUM_DDS + NUM_GATE + FIFO_DEPTH + 1 + NUM_CNT;
    localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 64 + 2000;
    // Generous wait for ack, covers back-pressure during the DDS run
    localparam int ACK_LIMIT       = 400;

    logic        rtio_clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        edge_sig;
    logic [31:0] dds_ftw;
    logic [13:0] dds_phase;
    logic [13:0] dds_amp;
    logic        dds_update;

    // Model state, expected {amp, phase, ftw} in push order
    logic [59:0] exp_q[$];
    int          dds_pulses;
    int          edge_model;

    tb_clk_gen #(.PERIOD_NS(4)) u_clk_gen (.clk_o(rtio_clk));

    rtio_core_top #(.FIFO_DEPTH(FIFO_DEPTH)) dut0 (
        .rtio_clk_i   (rtio_clk),
        .rst_n_i      (rst_n),
        .wb_cyc_i     (wb_cyc),
        .wb_stb_i     (wb_stb),
        .wb_we_i      (wb_we),
        .wb_adr_i     (wb_adr),
        .wb_dat_i     (wb_dat_w),
        .wb_dat_o     (wb_dat_r),
        .wb_ack_o     (wb_ack),
        .edge_sig_i   (edge_sig),
        .dds_ftw_o    (dds_ftw),
        .dds_phase_o  (dds_phase),
        .dds_amp_o    (dds_amp),
        .dds_update_o (dds_update)
    );

    //////////////////////////////
    // Checking helpers
    //////////////////////////////
    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic fail_run(input string why);
        $display("error at %0t ns: %s", $time, why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    //////////////////////////////
    // Wishbone master
    //////////////////////////////

    // One classic cycle, gives up after limit cycles without ack
    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             input int limit, output logic [31:0] rdat, output bit acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        @(posedge rtio_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        // Ack and read data sampled mid cycle
        while (!acked && waited < limit) begin
            @(negedge rtio_clk);
            if (wb_ack) begin
                acked = 1'b1;
                rdat  = wb_dat_r;
            end else begin
                waited++;
            end
        end
        @(posedge rtio_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] rdat;
        bit          acked;
        bus_cycle(1'b1, adr, dat, ACK_LIMIT, rdat, acked);
        if (!acked) fail_run($sformatf("no ack for write to 0x%02h", adr));
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] rdat);
        bit acked;
        bus_cycle(1'b0, adr, 32'h0, ACK_LIMIT, rdat, acked);
        if (!acked) fail_run($sformatf("no ack for read from 0x%02h", adr));
    endtask

    //////////////////////////////
    // Command helpers
    //////////////////////////////
    function automatic logic [63:0] rand_payload();
        return {$urandom(), $urandom()};
    endfunction

    function automatic bit is_mapped(input logic [7:0] adr);
        return adr inside {REG_CTRL, REG_STATUS, REG_TS_LO, REG_TS_HI, REG_PL_LO, REG_PL_HI,
                           REG_PUSH_DDS, REG_PUSH_CNT, REG_EDGE_COUNT};
    endfunction

    task automatic stage_command(input logic [63:0] ts, input logic [63:0] pl);
        wb_write(REG_TS_LO, ts[31:0]);
        wb_write(REG_TS_HI, ts[63:32]);
        wb_write(REG_PL_LO, pl[31:0]);
        wb_write(REG_PL_HI, pl[63:32]);
    endtask

    // Model learns a DDS command only once the push is acked
    task automatic push_staged(input bit to_cnt, input logic [63:0] pl, input int limit,
                               output bit acked);
        logic [31:0] rdat;
        bus_cycle(1'b1, to_cnt ? REG_PUSH_CNT : REG_PUSH_DDS, 32'h0, limit, rdat, acked);
        if (acked && !to_cnt) exp_q.push_back(pl[59:0]);
    endtask

    task automatic push_dds(input logic [63:0] ts, input logic [63:0] pl);
        bit acked;
        stage_command(ts, pl);
        push_staged(1'b0, pl, ACK_LIMIT, acked);
        if (!acked) fail_run("DDS push was never accepted");
    endtask

    task automatic wait_fifo_empty();
        logic [31:0] rdat;
        int          polls;
        polls = 0;
        rdat  = 32'hFFFF_FFFF;
        while (rdat[15:8] != 8'h00) begin
            if (polls == 1000) fail_run("FIFO did not empty");
            wb_read(REG_STATUS, rdat);
            polls++;
        end
    endtask

    // FIFO empty, then a few cycles so the last strobe has been seen
    task automatic wait_drain();
        wait_fifo_empty();
        repeat (3) @(posedge rtio_clk);
    endtask

    //////////////////////////////
    // Edge input stimulus
    //////////////////////////////

    // High at least 4 cycles, low at least 4 cycles
    task automatic drive_pulses(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge rtio_clk);
            edge_sig <= 1'b1;
            repeat ($urandom_range(4, 10)) @(posedge rtio_clk);
            edge_sig <= 1'b0;
            repeat ($urandom_range(3, 9)) @(posedge rtio_clk);
        end
    endtask

    task automatic edge_phase(input logic [3:0] ctrl, input int npulses);
        logic [31:0] rdat;
        bit          acked;
        stage_command(64'h0, {$urandom(), 28'($urandom()), ctrl});
        push_staged(1'b1, 64'h0, ACK_LIMIT, acked);
        if (!acked) fail_run("counter command was never accepted");
        wait_fifo_empty();
        repeat (2) @(posedge rtio_clk);
        // Clear zeroes, arm bits pick which edges count
        if (ctrl[2]) edge_model = 0;
        drive_pulses(npulses);
        edge_model += npulses * (int'(ctrl[0]) + int'(ctrl[1]));
        repeat (5) @(posedge rtio_clk);
        wb_read(REG_EDGE_COUNT, rdat);
        check("edge count", 64'(rdat), 64'(edge_model));
    endtask

    // DDS update monitor, settings stable at the falling edge
    always @(negedge rtio_clk) begin
        logic [59:0] exp;
        if (rst_n && dds_update) begin
            if (exp_q.size() == 0) begin
                fail_run("DDS update with no command pending");
            end else begin
                exp = exp_q.pop_front();
                dds_pulses++;
                check("dds_ftw", 64'(dds_ftw), 64'(exp[31:0]));
                check("dds_phase", 64'(dds_phase), 64'(exp[45:32]));
                check("dds_amp", 64'(dds_amp), 64'(exp[59:46]));
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge rtio_clk);
        $display("error: test timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        logic [63:0] ts;
        logic [63:0] pl;
        logic [31:0] rdat;
        logic [31:0] wval[4];
        logic [7:0]  adr;
        int          base;
        bit          acked;

        void'($urandom(71));
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        edge_sig   = 1'b0;
        dds_pulses = 0;
        edge_model = 0;
        repeat (10) @(posedge rtio_clk);
        rst_n <= 1'b1;

        // Reset state
        @(negedge rtio_clk);
        check("dds_ftw after reset", 64'(dds_ftw), 64'h0);
        check("dds_phase after reset", 64'(dds_phase), 64'h0);
        check("dds_amp after reset", 64'(dds_amp), 64'h0);
        wb_read(REG_STATUS, rdat);
        check("status after reset", 64'(rdat), 64'h0);
        wb_read(REG_EDGE_COUNT, rdat);
        check("edge count after reset", 64'(rdat), 64'h0);

        // Staging words read back, unmapped reads give 0
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 4; k++) begin
                wval[k] = $urandom();
                wb_write(8'(REG_TS_LO + 4 * k), wval[k]);
            end
            for (int k = 0; k < 4; k++) begin
                wb_read(8'(REG_TS_LO + 4 * k), rdat);
                check("staging readback", 64'(rdat), 64'(wval[k]));
            end
        end
        for (int n = 0; n < 6; n++) begin
            do adr = 8'($urandom()); while (is_mapped(adr));
            wb_read(adr, rdat);
            check("unmapped read", 64'(rdat), 64'h0);
        end

        // Ordered DDS run, time cleared and running
        wb_write(REG_CTRL, 32'h3);
        base = dds_pulses;
        ts   = 64'h0;
        for (int i = 0; i < NUM_DDS; i++) begin
            ts = ts + 64'($urandom_range(1, 20));
            push_dds(ts, rand_payload());
        end
        wait_drain();
        check("DDS pulse count", 64'(dds_pulses - base), 64'(NUM_DDS));

        // Time gating, nothing leaves while stopped
        wb_write(REG_CTRL, 32'h2);
        base = dds_pulses;
        ts   = 64'h0;
        for (int i = 0; i < NUM_GATE; i++) begin
            ts = ts + 64'($urandom_range(1, 8));
            push_dds(ts, rand_payload());
        end
        repeat (30) @(posedge rtio_clk);
        check("pulses while stopped", 64'(dds_pulses - base), 64'h0);
        wb_read(REG_STATUS, rdat);
        check("status level", 64'(rdat), 64'(NUM_GATE << 8));
        wb_write(REG_CTRL, 32'h1);
        wait_drain();
        check("gated pulse count", 64'(dds_pulses - base), 64'(NUM_GATE));

        // Back-pressure on a full FIFO
        wb_write(REG_CTRL, 32'h2);
        base = dds_pulses;
        ts   = 64'h0;
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            ts = ts + 64'($urandom_range(1, 4));
            push_dds(ts, rand_payload());
        end
        wb_read(REG_STATUS, rdat);
        check("status when full", 64'(rdat), 64'((FIFO_DEPTH << 8) | 1));
        ts = ts + 64'h1;
        pl = rand_payload();
        stage_command(ts, pl);
        // Stalled push is abandoned, then retried once running
        push_staged(1'b0, pl, 20, acked);
        check("ack on push while full", 64'(acked), 64'h0);
        wb_write(REG_CTRL, 32'h1);
        push_staged(1'b0, pl, ACK_LIMIT, acked);
        check("ack on push after run", 64'(acked), 64'h1);
        wait_drain();
        check("back-pressure pulse count", 64'(dds_pulses - base), 64'(FIFO_DEPTH + 1));

        // Edge counter, rising, then falling, then clear
        edge_phase(4'b0001, $urandom_range(3, 10));
        edge_phase(4'b0010, $urandom_range(3, 10));
        edge_phase(4'b0100, $urandom_range(2, 5));

        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
src/rtio_pkg.sv
src/rtio_edge_counter.sv
src/rtio_wb_slave.sv
src/rtio_event_fifo.sv
src/rtio_event_exec.sv
src/rtio_core_top.sv
test/tb_clk_gen.sv
test/rtio_core_sva.sv
test/rtio_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the RTIO core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module rtio_core_tb \
    -f filelist.f --Mdir obj_dir -o Vrtio_core_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vrtio_core_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "FAIL: testbench reported failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $run_status"
    exit 1
fi
echo "PASS"
exit 0
